// ==== compile.f ====
logic/videoPkg.sv
logic/rasterIf.sv
logic/pixelCen.sv
logic/rasterTiming.sv
logic/tileAddrGen.sv
logic/videoTop.sv
tb/tbClock.sv
tb/videoTop_props.sv
tb/videoTopTb.sv

// ==== logic/pixelCen.sv ====
// ##############################
// Pixel clock enable divider
// ##############################

`timescale 1ns/1ps

module pixelCen (
    input  logic clk,
    input  logic arstN,
    output logic pxlCen
);
    import videoPkg::*;

    logic [pxlCntW-1:0] divCnt;

    // Free-running modulo counter
    // Strobe registered on the terminal count, so the first pulse
    // lands pxlDiv clocks after reset goes away
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            divCnt <= '0;
            pxlCen <= 1'b0;
        end else begin
            pxlCen <= (divCnt == pxlLast);          // One clk wide
            if (divCnt == pxlLast) begin
                divCnt <= '0;                       // Wrap
            end else begin
                divCnt <= divCnt + 1'b1;
            end
        end
    end

endmodule

// ==== logic/rasterIf.sv ====
// ##############################
// Raster position bus
// ##############################

`timescale 1ns/1ps

interface rasterIf;

    logic [7:0] hPos;      // Flip already applied
    logic [7:0] vPos;      // Flip already applied
    logic       hBlank;
    logic       vBlank;
    logic       pxlCen;    // Pixel enable strobe

    // Timing generator side
    modport source (
        output hPos,
        output vPos,
        output hBlank,
        output vBlank,
        output pxlCen
    );

    // Address generator side
    modport sink (
        input hPos,
        input vPos,
        input hBlank,
        input vBlank,
        input pxlCen
    );

endinterface

// ==== logic/rasterTiming.sv ====
// ##############################
// Raster counters, blanking, sync
// and bus phase strobes
// ##############################

`timescale 1ns/1ps

module rasterTiming (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        flip,
    input  logic                        pxlCen,
    rasterIf.source                     raster,
    output logic                        hSync,
    output logic                        vSync,
    output logic [videoPkg::phaseW-1:0] phase
);
    import videoPkg::*;

    logic [8:0] hCnt;          // 0..383
    logic [8:0] hNext;
    logic       hWrap;
    logic [7:0] vCnt;
    logic [7:0] vPosQ;
    logic       hBlankQ;
    logic       vBlankQ;
    logic       vBlankArmed;   // Blank level for the next frame wrap
    logic       blankPass;     // Aux flag, second pass of the frame

    assign hWrap = (hCnt == hLast);
    assign hNext = hWrap ? 9'd0 : hCnt + 9'd1;

    // Flip handled here only
    assign raster.hPos   = hCnt[7:0] ^ {8{flip}};   // Combinational
    assign raster.vPos   = vPosQ;
    assign raster.hBlank = hBlankQ;
    assign raster.vBlank = vBlankQ;
    assign raster.pxlCen = pxlCen;

    // Vertical position follows the counter on every clk
    always_ff @(posedge clk) begin
        vPosQ <= vCnt ^ {8{flip}};
    end

    // Horizontal counter with blank and sync levels
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hCnt    <= '0;
            hBlankQ <= 1'b0;
            hSync   <= 1'b0;
        end else if (pxlCen) begin
            hCnt <= hNext;
            if (hCnt == hBlankStart) begin
                hBlankQ <= 1'b1;                    // End of active line
            end else if (hWrap) begin
                hBlankQ <= 1'b0;
            end
            if (hCnt == hSyncOn) begin
                hSync <= 1'b1;
            end else if (hCnt == hSyncOff) begin
                hSync <= 1'b0;                      // 20 enables wide
            end
        end
    end

    // Vertical counter, stepped at each line wrap
    // Visible pass 08..FF, then blanking pass E8..FF
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            vCnt        <= vInit;
            blankPass   <= 1'b0;
            vBlankArmed <= 1'b0;
            vBlankQ     <= 1'b0;
        end else if (pxlCen && hWrap) begin
            if (&vCnt) begin
                vBlankQ <= vBlankArmed;             // Takes effect with the new pass
                if (blankPass) begin
                    vCnt      <= vFirst;
                    blankPass <= 1'b0;
                end else begin
                    vCnt      <= vReload;           // Short pass of 24 lines
                    blankPass <= 1'b1;
                end
            end else begin
                vCnt <= vCnt + 8'd1;
            end
            // Decide blank for the coming wrap
            if (vCnt == vBlankArm) begin
                vBlankArmed <= !blankPass;
            end
        end
    end

    // Vertical sync
    // Sampled at horizontal sync start, only while blanking
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            vSync <= 1'b0;
        end else if (pxlCen && (hCnt == hSyncOn) && vBlankQ) begin
            if (vCnt == vSyncOn) begin
                vSync <= 1'b1;
            end else if (vCnt == vSyncOff) begin
                vSync <= 1'b0;                      // Four lines later
            end
        end
    end

    // Bus phases for CPU and video RAM slots
    // One-hot on odd counts, index from count bits 3:1
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            phase <= '0;
        end else if (pxlCen) begin
            phase <= '0;                            // Gap on even counts
            if (hNext[0] && (hNext[3:1] < 3'(phaseW))) begin
                phase[hNext[3:1]] <= 1'b1;
            end
        end
    end

endmodule

// ==== logic/tileAddrGen.sv ====
// ##############################
// Tile RAM address and in-tile
// pixel offsets
// ##############################

`timescale 1ns/1ps

module tileAddrGen (
    input  logic               clk,
    input  logic               arstN,
    rasterIf.sink              raster,
    output videoPkg::tileAddrT tileAddr,
    output logic [2:0]         fineH,
    output logic [2:0]         fineV,
    output logic               pixValid
);

    logic [4:0] tileRow;
    logic [4:0] tileCol;
    logic       inBlank;

    // 8x8 tiles, coarse part of each position picks the tile
    assign tileRow = raster.vPos[7:3];
    assign tileCol = raster.hPos[7:3];
    assign inBlank = raster.hBlank | raster.vBlank;

    // Address and offsets
    // Sampled once per pixel, flip already folded into the positions
    always_ff @(posedge clk) begin
        if (raster.pxlCen) begin
            tileAddr.rc.row <= tileRow;
            tileAddr.rc.col <= tileCol;
            fineH           <= raster.hPos[2:0];    // Column inside the tile
            fineV           <= raster.vPos[2:0];    // Row inside the tile
        end
    end

    // Qualifier aligned with the address above
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pixValid <= 1'b0;
        end else if (raster.pxlCen) begin
            pixValid <= !inBlank;
        end
    end

endmodule

// ==== logic/videoPkg.sv ====
// ##############################
// Video timing constants and the
// tile address type
// ##############################

package videoPkg;

    // Pixel clock divider
    localparam int pxlDiv  = 4;                    // System clocks per pixel
    localparam int pxlCntW = $clog2(pxlDiv);
    localparam logic [pxlCntW-1:0] pxlLast = pxlCntW'(pxlDiv - 1);

    // Horizontal raster
    localparam int         hTotal      = 384;      // Enables per line
    localparam logic [8:0] hLast       = 9'(hTotal - 1);
    localparam logic [8:0] hBlankStart = 9'd255;   // Last visible column
    localparam int         hBlankW     = hTotal - 1 - int'(hBlankStart);

    // Sync sits in the middle of blanking
    localparam logic [8:0] hSyncOn  = 9'(245 + hBlankW / 2);
    localparam logic [8:0] hSyncOff = 9'(265 + hBlankW / 2);

    // Vertical raster, two passes per frame
    localparam logic [7:0] vInit     = 8'hE0;      // Counter value out of reset
    localparam logic [7:0] vFirst    = 8'h08;      // Start of visible pass
    localparam logic [7:0] vReload   = 8'hE8;      // Start of blanking pass
    localparam logic [7:0] vBlankArm = 8'hF6;      // Blank decision for next wrap

    // Vertical sync window, only inside vBlank
    localparam logic [7:0] vSyncOn  = 8'hE9;
    localparam logic [7:0] vSyncOff = 8'hED;

    // CPU and video RAM slot strobes
    localparam int phaseW = 6;

    // Tile RAM address
    // Row/col pair for the address generator, linear index for the RAM
    typedef union packed {
        struct packed {
            logic [4:0] row;                       // vPos[7:3]
            logic [4:0] col;                       // hPos[7:3]
        } rc;
        logic [9:0] lin;                           // row*32 + col
    } tileAddrT;

endpackage

// ==== logic/videoTop.sv ====
// ##############################
// Video timing top level
// ##############################

`timescale 1ns/1ps

module videoTop (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        flip,
    output logic [7:0]                  hPos,
    output logic [7:0]                  vPos,
    output logic                        hBlank,
    output logic                        vBlank,
    output logic                        hSync,
    output logic                        vSync,
    output logic [videoPkg::phaseW-1:0] phase,
    output logic [9:0]                  tileLin,
    output logic [2:0]                  fineH,
    output logic [2:0]                  fineV,
    output logic                        pixValid,
    output logic                        pxlCen
);
    import videoPkg::*;

    rasterIf  rasterBus ();     // Timing to address generator
    tileAddrT tileAddr;

    pixelCen u_pixelCen (
        .clk    (clk),
        .arstN  (arstN),
        .pxlCen (pxlCen)
    );

    rasterTiming u_rasterTiming (
        .clk    (clk),
        .arstN  (arstN),
        .flip   (flip),
        .pxlCen (pxlCen),
        .raster (rasterBus.source),
        .hSync  (hSync),
        .vSync  (vSync),
        .phase  (phase)
    );

    tileAddrGen u_tileAddrGen (
        .clk      (clk),
        .arstN    (arstN),
        .raster   (rasterBus.sink),
        .tileAddr (tileAddr),
        .fineH    (fineH),
        .fineV    (fineV),
        .pixValid (pixValid)
    );

    // Raster bus out to the pins
    assign hPos    = rasterBus.hPos;
    assign vPos    = rasterBus.vPos;
    assign hBlank  = rasterBus.hBlank;
    assign vBlank  = rasterBus.vBlank;
    assign tileLin = tileAddr.lin;      // Linear view for the RAM

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the video timing testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module videoTopTb \
    --Mdir obj_dir -o videoTopSim \
    -f compile.f

# Status comes from the log, tee keeps the run going on a stop
./obj_dir/videoTopSim 2>&1 | tee sim.log

if grep -qx "Simulation PASSED" sim.log; then
    echo "run.sh: pass message found in sim.log"
    exit 0
fi

echo "run.sh: pass message missing from sim.log"
exit 1

// ==== tb/tbClock.sv ====
// ##############################
// Testbench clock source
// ##############################

`timescale 1ns/1ps

module tbClock (
    output logic clk
);
    localparam int halfPeriod = 50;     // 100 ns period

    initial begin
        clk = 1'b0;
        forever begin
            #halfPeriod clk = ~clk;
        end
    end

endmodule

// ==== tb/videoTopTb.sv ====
// ##############################
// Video timing testbench, raster
// model and directed tests
// ##############################

`timescale 1ns/1ps

module videoTopTb;
    import videoPkg::*;

    localparam int resetCycles = 5;
    localparam int enTimeout   = 4 * pxlDiv;    // Clks allowed between enables
    localparam int lineLimit   = 2 * hTotal;    // Enables to find a line edge
    localparam int frameLimit  = 300 * hTotal;  // Enables to find a frame edge

    logic              clk;
    logic              arstN;
    logic              flip;
    logic [7:0]        hPos;
    logic [7:0]        vPos;
    logic              hBlank;
    logic              vBlank;
    logic              hSync;
    logic              vSync;
    logic [phaseW-1:0] phase;
    logic [9:0]        tileLin;
    logic [2:0]        fineH;
    logic [2:0]        fineV;
    logic              pixValid;
    logic              pxlCen;

    int checkCnt;
    int errCount;
    int testErrStart;

    // Raster model, locked from blanking edges
    int   hModel;
    int   vModel;
    logic hLocked;
    logic vLocked;
    logic blankPass;
    logic lastHBlank;
    logic lastVBlank;

    tbClock u_tbClock (.clk(clk));

    videoTop u_videoTop (
        .clk      (clk),
        .arstN    (arstN),
        .flip     (flip),
        .hPos     (hPos),
        .vPos     (vPos),
        .hBlank   (hBlank),
        .vBlank   (vBlank),
        .hSync    (hSync),
        .vSync    (vSync),
        .phase    (phase),
        .tileLin  (tileLin),
        .fineH    (fineH),
        .fineV    (fineV),
        .pixValid (pixValid),
        .pxlCen   (pxlCen)
    );

    task automatic checkPos(input string what, input logic [7:0] got, input logic [7:0] exp);
        checkCnt++;
        if (got !== exp) begin
            errCount++;
            $display("[ERROR] %0t ns: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic checkTile(input string what, input tileAddrT got, input tileAddrT exp);
        checkCnt++;
        if (got !== exp) begin
            errCount++;
            $display("[ERROR] %0t ns: %s is row %0d col %0d, expected row %0d col %0d",
                     $time, what, got.rc.row, got.rc.col, exp.rc.row, exp.rc.col);
        end
    endtask

    task automatic checkLevel(input string what, input logic got, input logic exp);
        checkCnt++;
        if (got !== exp) begin
            errCount++;
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkCount(input string what, input int got, input int exp);
        checkCnt++;
        if (got != exp) begin
            errCount++;
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("Timeout at %0t ns: no %s seen in time", $time, what);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic endTest(input int num, input string name);
        $display("Test %0d (%s) done: %0d errors", num, name, errCount - testErrStart);
    endtask

    // Model counters, one step per enable
    task automatic updateModel();
        if (hBlank && !lastHBlank) begin
            hModel  = int'(hBlankStart) + 1;        // First blanked column
            hLocked = 1'b1;
        end else if (hLocked) begin
            if (hModel == hTotal - 1) begin
                hModel = 0;
                if (vModel == 255) begin
                    vModel    = blankPass ? int'(vFirst) : int'(vReload);
                    blankPass = !blankPass;         // Two passes per frame
                end else begin
                    vModel++;
                end
            end else begin
                hModel++;
            end
        end
        if (vBlank && !lastVBlank) begin
            vModel    = int'(vReload);              // Blanking pass starts
            blankPass = 1'b1;
            vLocked   = 1'b1;
        end
        lastHBlank = hBlank;
        lastVBlank = vBlank;
    endtask

    // Sample at negedge, one hit per pixel enable
    task automatic nextEnable(output int gap);
        gap = 0;
        do begin
            @(negedge clk);
            gap++;
            if (gap > enTimeout) timeoutFail("pixel enable");
        end while (!pxlCen);
        updateModel();
    endtask

    task automatic skipEnables(input int n);
        int gap;
        int i;
        for (i = 0; i < n; i++) begin
            nextEnable(gap);
        end
    endtask

    task automatic setFlip(input logic value);
        @(posedge clk);
        flip <= value;
        skipEnables(2);                             // vPos register catches up
    endtask

    task automatic checkQuiet(input string when);
        checkLevel({"hBlank ", when}, hBlank, 1'b0);
        checkLevel({"vBlank ", when}, vBlank, 1'b0);
        checkLevel({"hSync ", when}, hSync, 1'b0);
        checkLevel({"vSync ", when}, vSync, 1'b0);
        checkLevel({"phase ", when}, |phase, 1'b0);
        checkLevel({"pixValid ", when}, pixValid, 1'b0);
    endtask

    task automatic testReset();
        int n;
        int gap;
        testErrStart = errCount;
        for (n = 0; n < resetCycles; n++) begin
            @(negedge clk);
            checkQuiet("in reset");
        end
        @(posedge clk);
        arstN <= 1'b1;
        // Pulse rises pxlDiv clks after release, seen one negedge later
        gap = 0;
        do begin
            @(negedge clk);
            gap++;
            checkQuiet("before first enable");
            if (gap > enTimeout) timeoutFail("first pixel enable");
        end while (!pxlCen);
        updateModel();
        checkCount("first enable delay", gap, pxlDiv + 1);
        for (n = 0; n < 8; n++) begin
            nextEnable(gap);
            checkCount("enable spacing", gap, pxlDiv);
        end
        endTest(1, "reset state");
    endtask

    task automatic testLine();
        int   gap;
        int   n;
        int   blankN;
        int   syncN;
        int   syncRise;
        logic prevH;
        logic prevS;
        testErrStart = errCount;
        n = 0;
        do begin
            prevH = hBlank;
            nextEnable(gap);
            n++;
            if (n > lineLimit) timeoutFail("hBlank rise");
        end while (!(hBlank && !prevH));
        n        = 0;
        blankN   = 0;
        syncN    = 0;
        syncRise = -1;
        do begin
            prevH = hBlank;
            prevS = hSync;
            nextEnable(gap);
            n++;
            if (hBlank) blankN++;
            if (hSync) syncN++;
            if (hSync && !prevS) syncRise = n;
            if (n > lineLimit) timeoutFail("second hBlank rise");
        end while (!(hBlank && !prevH));
        checkCount("enables per line", n, hTotal);
        checkCount("hBlank enables", blankN, 128);
        checkCount("hSync delay after hBlank", syncRise, 54);
        checkCount("hSync enables", syncN, 20);
        endTest(2, "line timing");
    endtask

    task automatic testFrame();
        int   gap;
        int   n;
        int   rises;
        int   blankRises;
        int   syncEn;
        logic prevH;
        logic prevV;
        testErrStart = errCount;
        n = 0;
        do begin
            prevV = vBlank;
            nextEnable(gap);
            n++;
            if (n > frameLimit) timeoutFail("vBlank rise");
        end while (!(vBlank && !prevV));
        n          = 0;
        rises      = 0;
        blankRises = 0;
        syncEn     = 0;
        do begin
            prevH = hBlank;
            prevV = vBlank;
            nextEnable(gap);
            n++;
            if (hBlank && !prevH) begin
                rises++;                            // One per line
                if (vBlank) blankRises++;
            end
            if (vSync) begin
                syncEn++;
                checkLevel("vBlank while vSync", vBlank, 1'b1);
            end
            if (n > frameLimit) timeoutFail("second vBlank rise");
        end while (!(vBlank && !prevV));
        checkCount("lines per frame", rises, 272);
        checkCount("vBlank lines", blankRises, 24);
        checkCount("vSync enables", syncEn, 4 * hTotal);
        endTest(3, "frame timing");
    endtask

    task automatic testFlip();
        int   i;
        int   skip;
        logic flipVal;
        testErrStart = errCount;
        checkLevel("raster model locked", hLocked && vLocked, 1'b1);
        for (i = 0; i < 10; i++) begin
            if (i < 3) begin
                flipVal = 1'b0;
            end else if (i < 6) begin
                flipVal = 1'b1;
            end else begin
                flipVal = 1'($urandom % 2);
            end
            setFlip(flipVal);
            skip = 1 + int'($urandom % 1000);       // Random sample point
            skipEnables(skip);
            checkPos("hPos", hPos, 8'(hModel) ^ {8{flipVal}});
            checkPos("vPos", vPos, 8'(vModel) ^ {8{flipVal}});
        end
        endTest(4, "flip");
    endtask

    task automatic testTile();
        int         gap;
        int         f;
        int         n;
        logic [7:0] lastH;
        logic [7:0] lastV;
        logic       lastBlank;
        tileAddrT   got;
        tileAddrT   exp;
        testErrStart = errCount;
        for (f = 0; f < 2; f++) begin
            setFlip(1'(f));
            for (n = 0; n < 400; n++) begin
                lastH     = hPos;
                lastV     = vPos;
                lastBlank = hBlank | vBlank;
                nextEnable(gap);
                got.lin = tileLin;
                exp.lin = 10'(int'(lastV[7:3]) * 32 + int'(lastH[7:3]));
                checkTile("tile address", got, exp);
                checkPos("fineH", {5'b0, fineH}, {5'b0, lastH[2:0]});
                checkPos("fineV", {5'b0, fineV}, {5'b0, lastV[2:0]});
                checkLevel("pixValid", pixValid, !lastBlank);
            end
        end
        endTest(5, "tile address");
    endtask

    task automatic testPhase();
        int                gap;
        int                n;
        int                b;
        int                idx;
        int                last;
        int                pulses[phaseW];
        int                seenAt[phaseW];
        logic [phaseW-1:0] exp;
        testErrStart = errCount;
        last = -1;
        for (b = 0; b < phaseW; b++) begin
            pulses[b] = 0;
            seenAt[b] = -1;
        end
        for (n = 0; n < hTotal; n++) begin
            nextEnable(gap);
            idx = (hModel / 2) % 8;                 // Slot from the count
            exp = '0;
            if ((hModel % 2 == 1) && (idx < phaseW)) exp[idx] = 1'b1;
            for (b = 0; b < phaseW; b++) begin
                checkLevel($sformatf("phase[%0d]", b), phase[b], exp[b]);
                if (phase[b]) begin
                    pulses[b]++;
                    if (seenAt[b] >= 0) checkCount("phase spacing", n - seenAt[b], 16);
                    if (last >= 0) checkCount("phase order", b, (last + 1) % phaseW);
                    seenAt[b] = n;
                    last      = b;
                end
            end
        end
        for (b = 0; b < phaseW; b++) begin
            checkCount($sformatf("phase[%0d] pulses", b), pulses[b], hTotal / 16);
        end
        endTest(6, "bus phases");
    endtask

    initial begin
        arstN      = 1'b0;
        flip       = 1'b0;
        checkCnt   = 0;
        errCount   = 0;
        hModel     = 0;
        vModel     = 0;
        hLocked    = 1'b0;
        vLocked    = 1'b0;
        blankPass  = 1'b0;
        lastHBlank = 1'b0;
        lastVBlank = 1'b0;
        $timeformat(-9, 0, "", 0);                 // Report times in ns
        void'($urandom(32'h2810));
        testReset();
        testLine();
        testFrame();
        testFlip();
        testTile();
        testPhase();
        $display("Checks %0d, errors %0d", checkCnt, errCount);
        if (errCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/videoTop_props.sv ====
// ##############################
// Bound checks on phase, vSync
// and the pixel enable
// ##############################

`timescale 1ns/1ps

module videoTopProps (
    input logic                        clk,
    input logic                        arstN,
    input logic [videoPkg::phaseW-1:0] phase,
    input logic                        vSync,
    input logic                        vBlank,
    input logic                        pxlCen
);

    // One bus slot at a time, or none
    phaseOneHot: assert property (
        @(posedge clk) disable iff (!arstN) $onehot0(phase)
    ) else $error("phase has more than one bit set");

    // Vertical sync lives inside vertical blanking
    syncInBlank: assert property (
        @(posedge clk) disable iff (!arstN) vSync |-> vBlank
    ) else $error("vSync high outside vBlank");

    // Strobe is a single clk wide
    cenOneClk: assert property (
        @(posedge clk) disable iff (!arstN) pxlCen |=> !pxlCen
    ) else $error("pxlCen high for two clks in a row");

endmodule

bind videoTop videoTopProps u_videoTopProps (
    .clk    (clk),
    .arstN  (arstN),
    .phase  (phase),
    .vSync  (vSync),
    .vBlank (vBlank),
    .pxlCen (pxlCen)
);
